/* alut_pkg.sv */
//------------------------------
// shared types for the address lookup table
// hash is a plain byte xor, collisions overwrite
//------------------------------
package alut_pkg;

   // command op, bit 0 of reg_cmd
   typedef enum logic {
      op_learn  = 1'b0,
      op_lookup = 1'b1
   } alut_op_e;

   //------------------------------
   // table word, 83 bits
   //------------------------------
   typedef struct packed {
      logic        valid;      // entry in use
      logic [1:0]  port;       // switch port
      logic [31:0] stamp;      // time of learn
      logic [47:0] mac;
   } alut_entry_t;

   // slave -> address checker
   typedef struct packed {
      logic [47:0] mac;
      logic [1:0]  port;
      alut_op_e    op;
   } alut_cmd_t;

   // address checker -> slave
   typedef struct packed {
      logic       hit;
      logic [1:0] port;        // zero on a miss or a learn
   } alut_result_t;

   //------------------------------
   // register map, word addresses
   //------------------------------
   localparam logic [2:0] reg_mac_lo    = 3'd0; // mac[31:0]
   localparam logic [2:0] reg_mac_hi    = 3'd1; // [15:0] mac[47:32], [17:16] port
   localparam logic [2:0] reg_cmd       = 3'd2; // [0] op, write issues the command
   localparam logic [2:0] reg_status    = 3'd3; // [0] busy, [1] hit, [3:2] port, read only
   localparam logic [2:0] reg_age_limit = 3'd4; // 0 = aging off

   // xor of the six mac bytes
   function automatic logic [7:0] alut_hash(input logic [47:0] mac);
      logic [7:0] h;
      h = '0;
      for (int i = 0; i < 6; i++)
         h ^= mac[i*8 +: 8];
      return h;
   endfunction

endpackage

/* alut_mem.sv */
//------------------------------
// table ram, contents not reset
// one read or write per port per clock, read data one cycle later
//------------------------------
module alut_mem
#(
   parameter int DW = 83,
   parameter int DD = 256
)
(
   input  logic                  pclk15,
   input  logic [7:0]            addr_a,   // address checker side
   input  logic                  write_a,
   input  alut_pkg::alut_entry_t wdata_a,
   output alut_pkg::alut_entry_t rdata_a,
   input  logic [7:0]            addr_b,   // age checker side
   input  logic                  write_b,
   input  alut_pkg::alut_entry_t wdata_b,
   output alut_pkg::alut_entry_t rdata_b
);
   import alut_pkg::*;

   logic [DW-1:0] table_ram [DD];

   initial
      assert (DW == $bits(alut_entry_t))
      else $error("table width does not match entry type");

   // write-or-read on each port, read is old data
   always_ff @(posedge pclk15)
   begin
      if (write_a)
         table_ram[addr_a] <= wdata_a;
      else
         rdata_a <= table_ram[addr_a];
      if (write_b)
         table_ram[addr_b] <= wdata_b;
      else
         rdata_b <= table_ram[addr_b];
   end

   // age checker backs off on busy, so writes never meet
   a_no_write_clash: assert property (@(posedge pclk15)
      !(write_a && write_b && addr_a == addr_b));

endmodule

/* alut_wb_slave.sv */
//------------------------------
// wishbone classic slave, 32-bit, one command in flight
// reg_cmd write stalls ack until the checker takes it
//------------------------------
module alut_wb_slave
(
   input  logic                   pclk15,
   input  logic                   rst_n,
   input  logic [2:0]             adr,
   input  logic [31:0]            dat_w,
   input  logic                   we,
   input  logic                   cyc,
   input  logic                   stb,
   output logic [31:0]            dat_r,
   output logic                   ack,
   output alut_pkg::alut_cmd_t    cmd,
   output logic                   cmd_valid,
   input  logic                   cmd_ready,
   input  alut_pkg::alut_result_t result,
   input  logic                   result_valid,
   output logic [31:0]            age_limit
);
   import alut_pkg::*;

   typedef struct packed {
      logic [1:0] port;
      logic       hit;
      logic       busy;
   } status_t;

   logic [47:0] mac_r;
   logic [1:0]  port_r;
   alut_op_e    op_r;
   status_t     status;
   logic        req;       // bus cycle not yet acked
   logic        cmd_wr;    // command issue
   logic [31:0] rd_mux;

   assign req    = cyc & stb & ~ack;
   assign cmd_wr = req & we & (adr == reg_cmd);
   assign cmd    = '{mac: mac_r, port: port_r, op: op_r};

   // readback
   always_comb
   begin
      case (adr)
         reg_mac_lo:    rd_mux = mac_r[31:0];
         reg_mac_hi:    rd_mux = {14'd0, port_r, mac_r[47:32]};
         reg_cmd:       rd_mux = {31'd0, op_r};
         reg_status:    rd_mux = {28'd0, status};
         reg_age_limit: rd_mux = age_limit;
         default:       rd_mux = '0;
      endcase
   end

   //------------------------------
   // control, ack and command handshake
   //------------------------------
   always_ff @(posedge pclk15)
   begin
      if (!rst_n)
      begin
         ack       <= 1'b0;
         cmd_valid <= 1'b0;
         status    <= '0;
         age_limit <= '0;
      end
      else
      begin
         ack <= 1'b0;
         if (cmd_valid && cmd_ready)
         begin
            cmd_valid   <= 1'b0;   // taken, release the bus
            ack         <= 1'b1;
            status.busy <= 1'b1;
         end
         else if (cmd_wr && !cmd_valid && !status.busy)
            cmd_valid <= 1'b1;     // previous result must be in first
         else if (req && !cmd_wr)
         begin
            ack <= 1'b1;           // plain access, one cycle
            if (we && adr == reg_age_limit)
               age_limit <= dat_w;
         end
         if (result_valid)
         begin
            status.busy <= 1'b0;
            status.hit  <= result.hit;
            status.port <= result.port;
         end
      end
   end

   // host data and read data
   always_ff @(posedge pclk15)
   begin
      if (req && we)
      begin
         case (adr)
            reg_mac_lo: mac_r[31:0] <= dat_w;
            reg_mac_hi:
            begin
               mac_r[47:32] <= dat_w[15:0];
               port_r       <= dat_w[17:16];
            end
            reg_cmd:    op_r <= alut_op_e'(dat_w[0]);
            default:    ;                          // status is read only
         endcase
      end
      if (req && !we)
         dat_r <= rd_mux;
   end

   // host keeps stb up until it sees ack
   a_ack_needs_stb: assert property (@(posedge pclk15) disable iff (!rst_n)
      ack |-> stb);

endmodule

/* alut_addr_checker.sv */
//------------------------------
// learn and lookup against port a, table cleared by a 256-entry sweep
// commands are held off (cmd_ready low) until the sweep ends
//------------------------------
module alut_addr_checker
(
   input  logic                   pclk15,
   input  logic                   rst_n,
   input  alut_pkg::alut_cmd_t    cmd,
   input  logic                   cmd_valid,
   output logic                   cmd_ready,
   output alut_pkg::alut_result_t result,
   output logic                   result_valid,
   input  logic [31:0]            now,
   output logic                   busy,
   output logic [7:0]             addr_a,
   output logic                   write_a,
   output alut_pkg::alut_entry_t  wdata_a,
   input  alut_pkg::alut_entry_t  rdata_a
);
   import alut_pkg::*;

   typedef enum logic [1:0] {
      st_sweep,     // clear valid at every index
      st_idle,
      st_read,      // port a read in flight
      st_cmp        // read data back, compare
   } state_t;

   state_t      state;
   logic [7:0]  sweep_idx;
   logic [47:0] req_mac;     // mac under lookup
   logic        learn_done;  // result strobe for a learn
   logic        take;
   logic        match;

   assign cmd_ready = (state == st_idle);
   assign take      = cmd_valid & cmd_ready;
   assign busy      = (state != st_idle) | write_a; // covers the trailing write too
   assign match     = rdata_a.valid & (rdata_a.mac == req_mac);

   // lookup result straight off the ram output
   always_comb
   begin
      result_valid = learn_done | (state == st_cmp);
      result.hit   = (state == st_cmp) & match;
      result.port  = result.hit ? rdata_a.port : 2'b00;
   end

   //------------------------------
   // fsm and write strobe
   //------------------------------
   always_ff @(posedge pclk15)
   begin
      if (!rst_n)
      begin
         state      <= st_sweep;
         sweep_idx  <= '0;
         write_a    <= 1'b0;
         learn_done <= 1'b0;
      end
      else
      begin
         write_a    <= 1'b0;
         learn_done <= 1'b0;
         case (state)
            st_sweep:
            begin
               write_a   <= 1'b1;
               sweep_idx <= sweep_idx + 8'd1;
               if (sweep_idx == 8'hff)
                  state <= st_idle;
            end
            st_idle:
            begin
               if (take && cmd.op == op_learn)
               begin
                  write_a    <= 1'b1;   // single write cycle
                  learn_done <= 1'b1;
               end
               else if (take)
                  state <= st_read;
            end
            st_read: state <= st_cmp;
            st_cmp:  state <= st_idle;
            default: state <= st_idle;
         endcase
      end
   end

   // address and write data, no reset
   always_ff @(posedge pclk15)
   begin
      if (state == st_sweep)
      begin
         addr_a  <= sweep_idx;
         wdata_a <= '0;            // valid low
      end
      else if (take)
      begin
         req_mac <= cmd.mac;
         addr_a  <= alut_hash(cmd.mac);
         wdata_a <= '{valid: 1'b1, port: cmd.port, stamp: now, mac: cmd.mac};
      end
   end

   // slave clears busy on this strobe, so a second one would be lost
   a_result_pulse: assert property (@(posedge pclk15) disable iff (!rst_n)
      result_valid |=> !result_valid);

endmodule

/* alut_age_checker.sv */
//------------------------------
// free-running time and sweep on port b, 2 cycles per index
// entries skipped while busy wait for the next pass
//------------------------------
module alut_age_checker
#(
   parameter int DD = 256
)
(
   input  logic                  pclk15,
   input  logic                  rst_n,
   input  logic [31:0]           age_limit,  // 0 = off
   input  logic                  busy,
   output logic [31:0]           now,
   output logic [7:0]            addr_b,
   output logic                  write_b,
   output alut_pkg::alut_entry_t wdata_b,
   input  alut_pkg::alut_entry_t rdata_b
);
   localparam logic [7:0] last_idx = 8'(DD - 1);

   logic [7:0]  idx;
   logic        check;     // 0 read phase, 1 check phase
   logic        busy_q;    // busy during the read phase
   logic [31:0] age;
   logic        expired;

   assign age     = now - rdata_b.stamp;          // wraps cleanly
   assign expired = rdata_b.valid & (age_limit != 32'd0) & (age > age_limit);
   assign addr_b  = idx;

   // a port a write in either phase may have changed the word
   assign write_b = check & expired & ~busy & ~busy_q;

   // same entry, valid dropped
   always_comb
   begin
      wdata_b       = rdata_b;
      wdata_b.valid = 1'b0;
   end

   //------------------------------
   // time counter and sweep index
   //------------------------------
   always_ff @(posedge pclk15)
   begin
      if (!rst_n)
      begin
         now    <= '0;
         idx    <= '0;
         check  <= 1'b0;
         busy_q <= 1'b0;
      end
      else
      begin
         now    <= now + 32'd1;
         busy_q <= busy;
         check  <= ~check;
         if (check)
            idx <= (idx == last_idx) ? 8'd0 : idx + 8'd1;
      end
   end

endmodule

/* alut_top.sv */
//------------------------------
// lookup table top, wishbone in, status readback out
//------------------------------
module alut_top
#(
   parameter int DW = 83,
   parameter int DD = 256
)
(
   input  logic        pclk15,
   input  logic        rst_n,
   input  logic [2:0]  adr,
   input  logic [31:0] dat_w,
   output logic [31:0] dat_r,
   input  logic        we,
   input  logic        cyc,
   input  logic        stb,
   output logic        ack
);
   import alut_pkg::*;

   alut_cmd_t    cmd;
   logic         cmd_valid;
   logic         cmd_ready;
   alut_result_t result;
   logic         result_valid;
   logic [31:0]  age_limit;
   logic [31:0]  now;
   logic         busy;

   // ram ports
   logic [7:0]   addr_a;
   logic         write_a;
   alut_entry_t  wdata_a;
   alut_entry_t  rdata_a;
   logic [7:0]   addr_b;
   logic         write_b;
   alut_entry_t  wdata_b;
   alut_entry_t  rdata_b;

   alut_wb_slave u_slave (
      .pclk15, .rst_n, .adr, .dat_w, .we, .cyc, .stb, .dat_r, .ack,
      .cmd, .cmd_valid, .cmd_ready, .result, .result_valid, .age_limit
   );

   alut_addr_checker u_addr (
      .pclk15, .rst_n, .cmd, .cmd_valid, .cmd_ready, .result, .result_valid,
      .now, .busy, .addr_a, .write_a, .wdata_a, .rdata_a
   );

   alut_age_checker #(.DD(DD)) u_age (
      .pclk15, .rst_n, .age_limit, .busy, .now,
      .addr_b, .write_b, .wdata_b, .rdata_b
   );

   alut_mem #(.DW(DW), .DD(DD)) u_mem (
      .pclk15,
      .addr_a, .write_a, .wdata_a, .rdata_a,
      .addr_b, .write_b, .wdata_b, .rdata_b
   );

endmodule

/* tb_alut.sv */
//------------------------------
// testbench for the lookup table, Wishbone host plus reference table
// bus tasks start and end on a falling edge
//------------------------------
module tb_alut;
   import alut_pkg::*;

   localparam int DW = 83;
   localparam int DD = 256;
   localparam int num_ops   = 90;   // commands over all tests
   localparam int op_cycles = 40;   // bus budget per command
   localparam int reg_ops   = 8;    // plain register accesses
   localparam int timeout_cycles = 2 + DD + num_ops * op_cycles + reg_ops * 4
                                   + 3 * DD + 50 + 2 * DD + 4 + 500;

   logic        pclk15;
   logic        rst_n;
   logic [2:0]  adr;
   logic [31:0] dat_w;
   logic [31:0] dat_r;
   logic        we;
   logic        cyc;
   logic        stb;
   logic        ack;

   logic [31:0] rng_state = 32'h6a3eef48;
   int          cycle_cnt = 0;

   //------------------------------
   // reference table, one entry per index
   logic        ref_valid [DD];
   logic [47:0] ref_mac   [DD];
   logic [1:0]  ref_port  [DD];

   alut_result_t exp_q [$];          // predicted, in command order
   alut_result_t got_q [$];          // read back from status

   alut_top #(.DW(DW), .DD(DD)) DUT (
      .pclk15, .rst_n, .adr, .dat_w, .dat_r, .we, .cyc, .stb, .ack
   );

   initial
   begin
      pclk15 = 1'b0;
      forever #5 pclk15 = ~pclk15;
   end

   function automatic logic [31:0] next_rand();
      rng_state ^= rng_state << 13;
      rng_state ^= rng_state >> 17;
      rng_state ^= rng_state << 5;
      return rng_state;
   endfunction

   function automatic logic [47:0] random_mac();
      logic [31:0] lo;
      logic [31:0] hi;
      lo = next_rand();
      hi = next_rand();
      return {hi[15:0], lo};
   endfunction

   // byte xor of the mac
   function automatic logic [7:0] mac_index(input logic [47:0] mac);
      return mac[7:0] ^ mac[15:8] ^ mac[23:16] ^ mac[31:24] ^ mac[39:32] ^ mac[47:40];
   endfunction

   // learn gives no hit, lookup hits on a valid entry with the same mac
   function automatic alut_result_t predict_result(input logic [47:0] mac, input alut_op_e op);
      logic [7:0]   i;
      alut_result_t r;
      i = mac_index(mac);
      r = '0;
      if (op == op_lookup && ref_valid[i] && ref_mac[i] == mac)
      begin
         r.hit  = 1'b1;
         r.port = ref_port[i];
      end
      return r;
   endfunction

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1);
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
         abort_run($sformatf("[FAIL] %0t %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_result(input string name, input alut_result_t got,
                               input alut_result_t exp);
      if (got !== exp)
         abort_run($sformatf("[FAIL] %0t %s got hit=%0b port=%0d expected hit=%0b port=%0d",
                             $time, name, got.hit, got.port, exp.hit, exp.port));
   endtask

   //------------------------------
   // wishbone host
   task automatic wb_write(input logic [2:0] a, input logic [31:0] d);
      adr   = a;
      dat_w = d;
      we    = 1'b1;
      cyc   = 1'b1;
      stb   = 1'b1;
      @(negedge pclk15);
      while (!ack)
         @(negedge pclk15);
      @(negedge pclk15);             // stb held over the ack edge
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic wb_read(input logic [2:0] a, output logic [31:0] d);
      adr = a;
      we  = 1'b0;
      cyc = 1'b1;
      stb = 1'b1;
      @(negedge pclk15);
      while (!ack)
         @(negedge pclk15);
      d = dat_r;                     // latched with ack
      @(negedge pclk15);
      cyc = 1'b0;
      stb = 1'b0;
   endtask

   // load mac and port, issue, poll busy
   task automatic run_cmd(input logic [47:0] mac, input logic [1:0] port, input alut_op_e op);
      logic [31:0]  s;
      logic [7:0]   i;
      alut_result_t r;
      exp_q.push_back(predict_result(mac, op));
      if (op == op_learn)
      begin
         i = mac_index(mac);
         ref_valid[i] = 1'b1;        // collision overwrites
         ref_mac[i]   = mac;
         ref_port[i]  = port;
      end
      wb_write(reg_mac_lo, mac[31:0]);
      wb_write(reg_mac_hi, {14'd0, port, mac[47:32]});
      wb_write(reg_cmd, {31'd0, op});
      s = 32'd1;
      while (s[0])
         wb_read(reg_status, s);
      r.hit  = s[1];
      r.port = s[3:2];
      got_q.push_back(r);
   endtask

   always @(negedge pclk15)
   begin : compare_results
      alut_result_t got;
      alut_result_t exp;
      while (got_q.size() > 0 && exp_q.size() > 0)
      begin
         got = got_q.pop_front();
         exp = exp_q.pop_front();
         check_result("result", got, exp);
      end
   end

   always @(posedge pclk15)
   begin
      cycle_cnt++;
      if (cycle_cnt > timeout_cycles)
         abort_run($sformatf("timeout, run still going after %0d cycles", timeout_cycles));
   end

   //------------------------------
   initial
   begin : stimulus
      logic [47:0]  macs  [40];
      logic [1:0]   ports [40];
      logic [47:0]  mac_a;
      logic [47:0]  mac_b;
      logic [31:0]  word;
      logic [31:0]  s0;
      logic [31:0]  limit;
      alut_result_t last_res;
      for (int i = 0; i < DD; i++)
         ref_valid[i] = 1'b0;
      rst_n = 1'b0;
      adr   = '0;
      dat_w = '0;
      we    = 1'b0;
      cyc   = 1'b0;
      stb   = 1'b0;
      repeat (2) @(negedge pclk15);
      rst_n = 1'b1;

      // registers after reset, empty table
      wb_read(reg_status, word);
      check_word("status", word, 32'd0);
      wb_read(reg_age_limit, word);
      check_word("age_limit", word, 32'd0);
      run_cmd(random_mac(), 2'd0, op_lookup);

      // random learns then lookups
      for (int i = 0; i < 40; i++)
      begin
         macs[i]  = random_mac();
         word     = next_rand();
         ports[i] = word[1:0];
         run_cmd(macs[i], ports[i], op_learn);
      end
      for (int i = 0; i < 40; i++)
         run_cmd(macs[i], 2'd0, op_lookup);

      // same index, second learn wins
      mac_a = random_mac();
      mac_b = mac_a ^ 48'h0000_0000_a5a5;
      run_cmd(mac_a, 2'd1, op_learn);
      run_cmd(mac_b, 2'd2, op_learn);
      run_cmd(mac_b, 2'd0, op_lookup);
      run_cmd(mac_a, 2'd0, op_lookup);

      // aging off
      mac_a = random_mac();
      run_cmd(mac_a, 2'd3, op_learn);
      repeat (3 * DD) @(negedge pclk15);
      run_cmd(mac_a, 2'd0, op_lookup);

      // aging on, every entry is stale after the wait
      wb_write(reg_age_limit, 32'd50);
      mac_a = random_mac();
      run_cmd(mac_a, 2'd2, op_learn);
      repeat (50 + 2 * DD + 4) @(negedge pclk15);
      for (int i = 0; i < DD; i++)
         ref_valid[i] = 1'b0;
      run_cmd(mac_a, 2'd0, op_lookup);
      run_cmd(mac_a, 2'd2, op_learn);
      run_cmd(mac_a, 2'd0, op_lookup);

      // age limit readback, status is read only
      word = next_rand();
      wb_write(reg_age_limit, word);
      wb_read(reg_age_limit, limit);
      check_word("age_limit", limit, word);
      last_res = predict_result(mac_a, op_lookup);
      s0 = {28'd0, last_res.port, last_res.hit, 1'b0};   // busy low after the poll
      wb_read(reg_status, word);
      check_word("status", word, s0);
      wb_write(reg_status, ~s0);
      wb_read(reg_status, word);
      check_word("status", word, s0);

      repeat (2) @(negedge pclk15);
      $display("Everything OK");
      $finish;
   end

endmodule

/* tb.f */
alut_pkg.sv
alut_mem.sv
alut_wb_slave.sv
alut_addr_checker.sv
alut_age_checker.sv
alut_top.sv
tb_alut.sv

/* run.sh */
#!/bin/sh
# build and run the lookup table testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_alut -f tb.f -o tb_alut; then
   echo "verilator build failed"
   exit 1
fi

if ! ./obj_dir/tb_alut > sim.log 2>&1; then
   cat sim.log
   echo "simulation exited with an error"
   exit 1
fi

cat sim.log
if grep -q "Everything OK" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1
